// File: bus/addr_decoder.sv
// Address decoder to ROM, SRAM or error responder, with the registered response mux
`timescale 1ns/100ps

module addr_decoder #(
  parameter int unsigned NumWords = 4096
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  harness_pkg::bus_req_t             tgt_req_i,
  input  logic [harness_pkg::DataWidth-1:0] rom_rdata_i,
  input  logic [harness_pkg::DataWidth-1:0] ram_rdata_i,
  output harness_pkg::bus_rsp_t             tgt_rsp_o,
  output harness_pkg::bus_req_t             rom_req_o,
  output harness_pkg::bus_req_t             ram_req_o
);

  localparam logic [harness_pkg::AddrWidth-1:0] RamLength = NumWords * harness_pkg::StrbWidth;

  typedef enum logic {
    TgtRom,
    TgtRam
  } tgt_sel_e;

  logic [harness_pkg::AddrWidth-1:0] rom_offs;
  logic [harness_pkg::AddrWidth-1:0] ram_offs;
  logic                              rom_hit;
  logic                              ram_hit;
  tgt_sel_e                          sel_q;
  logic                              valid_q;
  logic                              we_q;
  logic                              err_q;

  // Offsets wrap below the base, so one compare covers both ends
  assign rom_offs = tgt_req_i.addr - harness_pkg::RomBase;
  assign ram_offs = tgt_req_i.addr - harness_pkg::RamBase;
  // ROM writes fall through to the error responder
  assign rom_hit  = (rom_offs < harness_pkg::RomLength) && !tgt_req_i.we;
  assign ram_hit  = ram_offs < RamLength;

  always_comb begin
    rom_req_o       = tgt_req_i;
    rom_req_o.valid = tgt_req_i.valid && rom_hit;
    ram_req_o       = tgt_req_i;
    ram_req_o.valid = tgt_req_i.valid && ram_hit;
  end

  // ------------------------------
  // Response side
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
      err_q   <= 1'b0;
      sel_q   <= TgtRom;
    end else begin
      valid_q <= tgt_req_i.valid;
      we_q    <= tgt_req_i.we;
      err_q   <= tgt_req_i.valid && !rom_hit && !ram_hit;
      sel_q   <= ram_hit ? TgtRam : TgtRom;
    end
  end

  always_comb begin
    tgt_rsp_o.valid = valid_q;
    tgt_rsp_o.err   = err_q;
    if (err_q) begin
      tgt_rsp_o.rdata = harness_pkg::ErrRdata;
    end else if (we_q) begin
      tgt_rsp_o.rdata = '0;
    end else if (sel_q == TgtRam) begin
      tgt_rsp_o.rdata = ram_rdata_i;
    end else begin
      tgt_rsp_o.rdata = rom_rdata_i;
    end
  end

endmodule

// File: bus/bus_arbiter.sv
// Two-master round-robin arbiter with a one-entry hold slot and response steering
`timescale 1ns/100ps

module bus_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  harness_pkg::bus_req_t core_req_i,
  input  harness_pkg::bus_req_t dbg_req_i,
  input  harness_pkg::bus_rsp_t tgt_rsp_i,
  output harness_pkg::bus_rsp_t core_rsp_o,
  output harness_pkg::bus_rsp_t dbg_rsp_o,
  output harness_pkg::bus_req_t tgt_req_o
);

  harness_pkg::bus_req_t tgt_req_d, tgt_req_q;
  harness_pkg::bus_req_t hold_d, hold_q;
  harness_pkg::mst_sel_e tgt_owner_d, tgt_owner_q;
  harness_pkg::mst_sel_e hold_owner_d, hold_owner_q;
  harness_pkg::mst_sel_e last_d, last_q;
  // Owner of the access that the target answers this cycle
  harness_pkg::mst_sel_e rsp_owner_q;

  // ------------------------------
  // Grant
  // ------------------------------
  always_comb begin
    tgt_req_d    = '0;
    tgt_owner_d  = tgt_owner_q;
    hold_d       = '0;
    hold_owner_d = hold_owner_q;
    last_d       = last_q;
    if (hold_q.valid) begin
      // Last cycle's loser goes out first; masters are idle meanwhile
      tgt_req_d   = hold_q;
      tgt_owner_d = hold_owner_q;
    end else if (core_req_i.valid && dbg_req_i.valid) begin
      if (last_q == harness_pkg::MstCore) begin
        tgt_req_d    = dbg_req_i;
        tgt_owner_d  = harness_pkg::MstDebug;
        hold_d       = core_req_i;
        hold_owner_d = harness_pkg::MstCore;
      end else begin
        tgt_req_d    = core_req_i;
        tgt_owner_d  = harness_pkg::MstCore;
        hold_d       = dbg_req_i;
        hold_owner_d = harness_pkg::MstDebug;
      end
      last_d = tgt_owner_d;
    end else if (core_req_i.valid) begin
      tgt_req_d   = core_req_i;
      tgt_owner_d = harness_pkg::MstCore;
      last_d      = harness_pkg::MstCore;
    end else if (dbg_req_i.valid) begin
      tgt_req_d   = dbg_req_i;
      tgt_owner_d = harness_pkg::MstDebug;
      last_d      = harness_pkg::MstDebug;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_req_q    <= '0;
      hold_q       <= '0;
      tgt_owner_q  <= harness_pkg::MstCore;
      hold_owner_q <= harness_pkg::MstCore;
      last_q       <= harness_pkg::MstDebug;
      rsp_owner_q  <= harness_pkg::MstCore;
    end else begin
      tgt_req_q    <= tgt_req_d;
      hold_q       <= hold_d;
      tgt_owner_q  <= tgt_owner_d;
      hold_owner_q <= hold_owner_d;
      last_q       <= last_d;
      rsp_owner_q  <= tgt_owner_q;
    end
  end

  assign tgt_req_o = tgt_req_q;

  // Response return
  always_comb begin
    core_rsp_o = '0;
    dbg_rsp_o  = '0;
    if (rsp_owner_q == harness_pkg::MstCore) begin
      core_rsp_o = tgt_rsp_i;
    end else begin
      dbg_rsp_o = tgt_rsp_i;
    end
  end

endmodule

// File: common/harness_pkg.sv
// Bus widths, address map, bus request and response structs, boot image, error word
package harness_pkg;

  // ------------------------------
  // Bus geometry
  // ------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam logic [31:0] RomBase   = 32'h0000_1000;
  localparam logic [31:0] RomLength = 32'h0000_1000;
  // SRAM length is set by the NumWords parameter
  localparam logic [31:0] RamBase   = 32'h8000_0000;

  // Boot image, words past the end read as zero
  localparam int unsigned RomWords = 16;
  localparam logic [DataWidth-1:0] RomImage [RomWords] = '{
    32'h0000_0297,
    32'h0202_8593,
    32'hF140_2573,
    32'h0182_A283,
    32'h0002_8067,
    32'h0000_0013,
    32'h8000_0000,
    32'h0000_0000,
    32'hDEAD_BEEF,
    32'h1234_5678,
    32'hA5A5_5A5A,
    32'h0F0F_F0F0,
    32'hCAFE_F00D,
    32'h0000_FFFF,
    32'hFFFF_0000,
    32'h1001_0073
  };

  // Returned on unmapped accesses and ROM writes
  localparam logic [31:0] ErrRdata = 32'hBADC_0FFE;

  // ------------------------------
  // Bus structs
  // ------------------------------
  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } bus_rsp_t;

  typedef enum logic {
    MstCore  = 1'b0,
    MstDebug = 1'b1
  } mst_sel_e;

endpackage

// File: hdl/debug_req_gate.sv
// Post-reset hold-off counter and enable mask for the core debug request
`timescale 1ns/100ps

module debug_req_gate #(
  parameter int unsigned DelayCycles = 20
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = (DelayCycles > 0) ? $clog2(DelayCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_q;

  // Counts down once after reset, then parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Core only sees the request once the window has closed
  assign debug_req_o = (cnt_q == '0) && debug_en_i && debug_req_i;

endmodule

// File: hdl/harness_top.sv
// Harness top level: debug request gate, bus arbiter, address decoder, ROM and SRAM
`timescale 1ns/100ps

module harness_top #(
  parameter int unsigned NumWords       = 4096,
  parameter int unsigned DbgDelayCycles = 20
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  harness_pkg::bus_req_t core_req_i,
  input  harness_pkg::bus_req_t dbg_req_i,
  output harness_pkg::bus_rsp_t core_rsp_o,
  output harness_pkg::bus_rsp_t dbg_rsp_o,
  input  logic                  debug_req_i,
  input  logic                  debug_en_i,
  output logic                  core_debug_req_o
);

  harness_pkg::bus_req_t tgt_req;
  harness_pkg::bus_rsp_t tgt_rsp;
  harness_pkg::bus_req_t rom_req;
  harness_pkg::bus_req_t ram_req;

  logic [harness_pkg::DataWidth-1:0] rom_rdata;
  logic [harness_pkg::DataWidth-1:0] ram_rdata;

  // Debug request to the core, held off after reset
  debug_req_gate #(
    .DelayCycles ( DbgDelayCycles )
  ) i_debug_req_gate (
    .clk_i       ( clk_i            ),
    .rst_ni      ( rst_ni           ),
    .debug_req_i ( debug_req_i      ),
    .debug_en_i  ( debug_en_i       ),
    .debug_req_o ( core_debug_req_o )
  );

  // ------------------------------
  // Memory bus
  // ------------------------------
  bus_arbiter i_bus_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .core_req_i ( core_req_i ),
    .dbg_req_i  ( dbg_req_i  ),
    .tgt_rsp_i  ( tgt_rsp    ),
    .core_rsp_o ( core_rsp_o ),
    .dbg_rsp_o  ( dbg_rsp_o  ),
    .tgt_req_o  ( tgt_req    )
  );

  addr_decoder #(
    .NumWords ( NumWords )
  ) i_addr_decoder (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .tgt_req_i   ( tgt_req   ),
    .rom_rdata_i ( rom_rdata ),
    .ram_rdata_i ( ram_rdata ),
    .tgt_rsp_o   ( tgt_rsp   ),
    .rom_req_o   ( rom_req   ),
    .ram_req_o   ( ram_req   )
  );

  boot_rom i_boot_rom (
    .clk_i     ( clk_i     ),
    .rom_req_i ( rom_req   ),
    .rdata_o   ( rom_rdata )
  );

  data_sram #(
    .NumWords ( NumWords )
  ) i_data_sram (
    .clk_i     ( clk_i     ),
    .ram_req_i ( ram_req   ),
    .rdata_o   ( ram_rdata )
  );

endmodule

// File: mem/boot_rom.sv
// Boot ROM holding the package image, registered read
`timescale 1ns/100ps

module boot_rom (
  input  logic                              clk_i,
  input  harness_pkg::bus_req_t             rom_req_i,
  output logic [harness_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned ByteBits = $clog2(harness_pkg::StrbWidth);
  localparam int unsigned IdxWidth = $clog2(harness_pkg::RomWords);

  logic [harness_pkg::AddrWidth-1:0] byte_offs;
  logic [harness_pkg::AddrWidth-1:0] word_offs;

  assign byte_offs = rom_req_i.addr - harness_pkg::RomBase;
  assign word_offs = byte_offs >> ByteBits;

  always_ff @(posedge clk_i) begin
    if (rom_req_i.valid) begin
      // Rest of the 4 KiB region reads as zero
      if (word_offs < harness_pkg::RomWords) begin
        rdata_o <= harness_pkg::RomImage[word_offs[IdxWidth-1:0]];
      end else begin
        rdata_o <= '0;
      end
    end
  end

endmodule

// File: mem/data_sram.sv
// Word-addressed data SRAM with byte enables and registered read
`timescale 1ns/100ps

module data_sram #(
  parameter int unsigned NumWords = 4096
) (
  input  logic                              clk_i,
  input  harness_pkg::bus_req_t             ram_req_i,
  output logic [harness_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned ByteBits = $clog2(harness_pkg::StrbWidth);
  localparam int unsigned IdxWidth = $clog2(NumWords);

  logic [harness_pkg::DataWidth-1:0] mem_q [NumWords];
  logic [harness_pkg::AddrWidth-1:0] byte_offs;
  logic [IdxWidth-1:0]               idx;

  // Decoder has already checked the range
  assign byte_offs = ram_req_i.addr - harness_pkg::RamBase;
  assign idx       = byte_offs[IdxWidth+ByteBits-1:ByteBits];

  // ------------------------------
  // Write with byte merge, read
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (ram_req_i.valid) begin
      if (ram_req_i.we) begin
        for (int b = 0; b < harness_pkg::StrbWidth; b++) begin
          if (ram_req_i.be[b]) begin
            mem_q[idx][8*b +: 8] <= ram_req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the harness testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_harness -f vlog.f > build.log 2>&1 \
  && ./obj_dir/Vtb_harness > sim.log 2>&1 \
  || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "CHECKS FAILED" sim.log \
  && { echo "Simulation FAILED, see sim.log"; exit 1; } \
  || true
grep -q "ALL CHECKS PASSED" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation ended without a result, see sim.log"; exit 1; }

// File: tb/harness_checker.sv
// Response and debug-gate checker for the harness testbench, with error counting
`timescale 1ns/100ps

module harness_checker #(
  parameter int unsigned DbgDelayCycles = 20
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  harness_pkg::bus_rsp_t core_rsp_i,
  input  harness_pkg::bus_rsp_t dbg_rsp_i,
  input  logic                  debug_req_i,
  input  logic                  debug_en_i,
  input  logic                  core_debug_req_i
);

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic        contested;
    logic [31:0] issue;
  } exp_t;

  exp_t        core_q [$];
  exp_t        dbg_q  [$];
  int unsigned cyc = 0;
  int unsigned rel_cyc = 0;
  int unsigned err_cnt = 0;
  int unsigned check_cnt = 0;
  int unsigned lat2_cnt = 0;
  int unsigned lat3_cnt = 0;
  logic        dbg_seen_high = 1'b0;
  logic        exp_dbg;

  // Called by the driver when an access goes out
  function automatic void expect_rsp(input logic mst, input logic [31:0] rdata,
                                     input logic err, input logic contested);
    exp_t e;
    e.rdata     = rdata;
    e.err       = err;
    e.contested = contested;
    e.issue     = cyc;
    if (mst) begin
      dbg_q.push_back(e);
    end else begin
      core_q.push_back(e);
    end
  endfunction

  task automatic compare_rsp(input string name, input harness_pkg::bus_rsp_t rsp, input exp_t e);
    int unsigned lat;
    lat = cyc - e.issue;
    check_cnt++;
    if (rsp.rdata !== e.rdata) begin
      $display("CHECK FAILED %s.rdata: got %h, expected %h", name, rsp.rdata, e.rdata);
      err_cnt++;
    end
    if (rsp.err !== e.err) begin
      $display("CHECK FAILED %s.err: got %h, expected %h", name, rsp.err, e.err);
      err_cnt++;
    end
    // Loser of a tie is one cycle behind the winner
    if (e.contested && lat == 2) begin
      lat2_cnt++;
    end else if (e.contested && lat == 3) begin
      lat3_cnt++;
    end else if (e.contested || lat != 2) begin
      $display("%s answered %0d cycles after its request, which is outside the allowed timing",
               name, lat);
      err_cnt++;
    end
  endtask

  // ------------------------------
  // Cycle counters
  // ------------------------------
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rel_cyc <= 0;
    end else if (rel_cyc < 32'hFFFF) begin
      rel_cyc <= rel_cyc + 1;
    end
  end

  // Outputs are sampled mid-cycle away from the edges
  always @(negedge clk_i) begin
    if (!rst_ni && (core_rsp_i.valid !== 1'b0 || dbg_rsp_i.valid !== 1'b0)) begin
      $display("A response strobe was active while reset was asserted");
      err_cnt++;
    end
    if (rst_ni && core_rsp_i.valid === 1'b1) begin
      if (core_q.size() == 0) begin
        $display("core_rsp_o gave a response with no access outstanding");
        err_cnt++;
      end else begin
        compare_rsp("core_rsp_o", core_rsp_i, core_q.pop_front());
      end
    end
    if (rst_ni && dbg_rsp_i.valid === 1'b1) begin
      if (dbg_q.size() == 0) begin
        $display("dbg_rsp_o gave a response with no access outstanding");
        err_cnt++;
      end else begin
        compare_rsp("dbg_rsp_o", dbg_rsp_i, dbg_q.pop_front());
      end
    end
    if (core_q.size() > 0 && cyc - core_q[0].issue > 3) begin
      $display("core_rsp_o gave no response within 3 cycles of the request");
      void'(core_q.pop_front());
      err_cnt++;
    end
    if (dbg_q.size() > 0 && cyc - dbg_q[0].issue > 3) begin
      $display("dbg_rsp_o gave no response within 3 cycles of the request");
      void'(dbg_q.pop_front());
      err_cnt++;
    end
    // ------------------------------
    // Debug request gate
    // ------------------------------
    exp_dbg = (rst_ni && rel_cyc >= DbgDelayCycles) ? (debug_req_i & debug_en_i) : 1'b0;
    if (core_debug_req_i !== exp_dbg) begin
      $display("CHECK FAILED core_debug_req_o: got %h, expected %h", core_debug_req_i, exp_dbg);
      err_cnt++;
    end
    if (core_debug_req_i === 1'b1) begin
      dbg_seen_high = 1'b1;
    end
  end

  // Returns the number of errors found at the end of the run
  function automatic int unsigned final_checks();
    int unsigned n;
    n = 0;
    if (lat2_cnt != lat3_cnt) begin
      $display("Contested pairs did not split into one 2-cycle and one 3-cycle response");
      n++;
    end
    if (!dbg_seen_high) begin
      $display("The debug request never reached the core");
      n++;
    end
    return n;
  endfunction

endmodule

// File: tb/harness_vectors.txt
# pair mst we addr be wdata exp_rdata exp_err, all hex; mst 0 is the core port, 1 the debug port
# pair 1 issues this line and the next one in the same cycle
0 0 0 00001000 0 00000000 00000297 0
0 1 0 00001008 0 00000000 F1402573 0
0 0 0 00001020 0 00000000 DEADBEEF 0
0 1 0 0000103C 0 00000000 10010073 0
0 0 0 00001040 0 00000000 00000000 0
0 1 0 00001FFC 0 00000000 00000000 0
0 0 1 80000000 F 11223344 00000000 0
0 0 1 80000000 5 AABBCCDD 00000000 0
0 1 0 80000000 0 00000000 11BB33DD 0
0 1 1 80000010 F CAFEBABE 00000000 0
0 0 1 80000010 8 99000000 00000000 0
0 0 0 80000010 0 00000000 99FEBABE 0
0 0 0 00000000 0 00000000 BADC0FFE 1
0 1 1 00001004 F 55555555 BADC0FFE 1
0 0 0 00001004 0 00000000 02028593 0
0 1 1 80004000 F 12345678 BADC0FFE 1
0 0 0 80000000 0 00000000 11BB33DD 0
1 0 0 0000100C 0 00000000 0182A283 0
0 1 0 80000010 0 00000000 99FEBABE 0
1 0 1 80000020 F 0000BEEF 00000000 0
0 1 0 00001030 0 00000000 CAFEF00D 0
1 1 0 00001024 0 00000000 12345678 0
0 0 0 80000000 0 00000000 11BB33DD 0
1 0 0 40000000 0 00000000 BADC0FFE 1
0 1 1 80000020 2 0000AA00 00000000 0
0 0 0 80000020 0 00000000 0000AAEF 0

// File: tb/tb_harness.sv
// Harness testbench: clock, reset, vector-file driver, random idle gaps, watchdog
`timescale 1ns/100ps

module tb_harness;

  localparam int unsigned NumWords       = 4096;
  localparam int unsigned DbgDelayCycles = 20;
  localparam int unsigned ClkPeriod      = 10;
  localparam int unsigned ResetCycles    = 5;
  localparam int unsigned DriveDelay     = 1;
  localparam int unsigned RspWaitLimit   = 8;

  typedef struct packed {
    logic        pair;
    logic        mst;
    logic        we;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
  } vec_t;

  logic                  clk;
  logic                  rst_n;
  harness_pkg::bus_req_t core_req;
  harness_pkg::bus_req_t dbg_req;
  harness_pkg::bus_rsp_t core_rsp;
  harness_pkg::bus_rsp_t dbg_rsp;
  logic                  debug_req;
  logic                  debug_en;
  logic                  core_debug_req;
  vec_t                  vecs [$];
  logic [31:0]           rand_state;
  logic                  load_done;
  int unsigned           drv_errs;

  harness_top #(
    .NumWords       ( NumWords       ),
    .DbgDelayCycles ( DbgDelayCycles )
  ) DUT (
    .clk_i            ( clk            ),
    .rst_ni           ( rst_n          ),
    .core_req_i       ( core_req       ),
    .dbg_req_i        ( dbg_req        ),
    .core_rsp_o       ( core_rsp       ),
    .dbg_rsp_o        ( dbg_rsp        ),
    .debug_req_i      ( debug_req      ),
    .debug_en_i       ( debug_en       ),
    .core_debug_req_o ( core_debug_req )
  );

  harness_checker #(
    .DbgDelayCycles ( DbgDelayCycles )
  ) u_checker (
    .clk_i            ( clk            ),
    .rst_ni           ( rst_n          ),
    .core_rsp_i       ( core_rsp       ),
    .dbg_rsp_i        ( dbg_rsp        ),
    .debug_req_i      ( debug_req      ),
    .debug_en_i       ( debug_en       ),
    .core_debug_req_i ( core_debug_req )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic load_vectors(output logic ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [8];
    vec_t        v;
    ok = 1'b0;
    fd = $fopen("tb/harness_vectors.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5],
                      f[6], f[7]);
          if (n == 8) begin
            v = {f[0][0], f[1][0], f[2][0], f[3], f[4][3:0], f[5], f[6], f[7][0]};
            vecs.push_back(v);
          end
        end
      end
      $fclose(fd);
      ok = (vecs.size() > 0);
    end
  endtask

  task automatic put_req(input vec_t v, input logic contested);
    harness_pkg::bus_req_t r;
    r = {1'b1, v.we, v.addr, v.be, v.wdata};
    if (v.mst) begin
      dbg_req = r;
    end else begin
      core_req = r;
    end
    u_checker.expect_rsp(v.mst, v.exp_rdata, v.exp_err, contested);
  endtask

  // Handshake wait on the response strobes, bounded
  task automatic wait_rsp(input logic want_core, input logic want_dbg);
    int unsigned n;
    logic        core_open;
    logic        dbg_open;
    core_open = want_core;
    dbg_open  = want_dbg;
    n         = 0;
    while ((core_open || dbg_open) && n < RspWaitLimit) begin
      @(negedge clk);
      if (core_rsp.valid === 1'b1) core_open = 1'b0;
      if (dbg_rsp.valid === 1'b1) dbg_open = 1'b0;
      n++;
    end
    if (core_open || dbg_open) begin
      $display("Driver gave up waiting for a response after %0d cycles", RspWaitLimit);
      drv_errs++;
    end
  endtask

  task automatic run_access(input vec_t a, input vec_t b, input logic contested);
    @(posedge clk);
    #DriveDelay;
    put_req(a, contested);
    if (contested) put_req(b, 1'b1);
    @(posedge clk);
    #DriveDelay;
    core_req = '0;
    dbg_req  = '0;
    wait_rsp(!a.mst || contested, a.mst || contested);
    if (!contested) begin
      rand_state = xorshift32(rand_state);
      repeat (rand_state[1:0]) @(posedge clk);
    end
  endtask

  // ------------------------------
  // Debug gate stimulus
  // ------------------------------
  task automatic run_debug_gate();
    int unsigned i;
    // Request already high through the hold-off window
    repeat (DbgDelayCycles + 4) @(posedge clk);
    for (i = 0; i < 4; i++) begin
      @(posedge clk);
      #DriveDelay;
      debug_req = i[0];
      debug_en  = i[1];
      repeat (2) @(posedge clk);
    end
    for (i = 0; i < 12; i++) begin
      @(posedge clk);
      #DriveDelay;
      rand_state = xorshift32(rand_state);
      debug_req  = rand_state[0];
      debug_en   = rand_state[1];
    end
  endtask

  initial begin : main_seq
    logic        ok;
    int unsigned i;
    int unsigned total;
    rst_n      = 1'b0;
    core_req   = '0;
    dbg_req    = '0;
    debug_req  = 1'b1;
    debug_en   = 1'b1;
    rand_state = 32'h499;
    drv_errs   = 0;
    load_done  = 1'b0;
    load_vectors(ok);
    load_done = 1'b1;
    if (!ok) begin
      $display("No vectors could be read from tb/harness_vectors.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      repeat (ResetCycles) @(posedge clk);
      #DriveDelay;
      rst_n = 1'b1;
      run_debug_gate();
      i = 0;
      while (i < vecs.size()) begin
        if (vecs[i].pair && (i + 1 >= vecs.size() || vecs[i+1].mst == vecs[i].mst)) begin
          $display("Vector %0d starts a pair without a partner on the other master", i);
          drv_errs++;
          i++;
        end else if (vecs[i].pair) begin
          run_access(vecs[i], vecs[i+1], 1'b1);
          i += 2;
        end else begin
          run_access(vecs[i], vecs[i], 1'b0);
          i++;
        end
      end
      repeat (4) @(posedge clk);
      total = u_checker.err_cnt + u_checker.final_checks() + drv_errs;
      $display("Summary: %0d vectors, %0d responses checked, %0d errors", vecs.size(),
               u_checker.check_cnt, total);
      if (total == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

  // Limit scales with the number of vectors
  initial begin : watchdog
    int unsigned limit;
    wait (load_done);
    limit = vecs.size() * 8 + 200;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the run completed", limit);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: vlog.f
common/harness_pkg.sv
hdl/debug_req_gate.sv
bus/bus_arbiter.sv
bus/addr_decoder.sv
mem/boot_rom.sv
mem/data_sram.sv
hdl/harness_top.sv
tb/harness_checker.sv
tb/tb_harness.sv
